//--- logic/bikeDisplayPkg.sv
`default_nettype none

package bikeDisplayPkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ReadingBits = 16;
  localparam int DigitBits   = 4;
  localparam int SegmentBits = 7;
  localparam int NumDigits   = 4;
  // Also the number of shift steps in the converter
  localparam int ScaledBits  = 10;
  // Digits 2..0 carry a decimal point
  localparam int PointDigits = NumDigits - 1;

  typedef logic [ReadingBits-1:0] reading_t;
  typedef logic [ScaledBits-1:0]  scaled_t;
  typedef logic [DigitBits-1:0]   bcdDigit_t;
  // Segment A in the top bit, G in the bottom bit
  typedef logic [SegmentBits-1:0] segments_t;
  typedef logic [NumDigits-1:0]   digitSelect_t;
  typedef logic [PointDigits-1:0] pointMask_t;

  typedef enum logic [1:0] {
    speed,
    aveSpeed,
    cadence,
    calories
  } displayMode_t;

  ////////////////////
  // Segment tables
  ////////////////////

  localparam segments_t digitGlyphs [0:9] = '{
    7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
    7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_1011
  };

  // Letter shown on digit 3, in mode order
  localparam segments_t modeGlyphs [0:3] = '{
    7'b001_1000,  // speed
    7'b101_1011,  // average speed
    7'b000_1101,  // cadence
    7'b100_1110   // calories
  };

  ////////////////////
  // Scaling
  ////////////////////

  // Fixed fractional digits of the raw reading, per mode
  localparam int fractionDigits [0:3] = '{1, 1, 0, 0};

  localparam reading_t SingleLimit = 16'd1000;
  localparam reading_t TenLimit    = 16'd10000;
  localparam reading_t ScaleStep   = 16'd10;

endpackage

`default_nettype wire

//--- logic/conversionIf.sv
`default_nettype none

// One scaled reading on its way to the BCD converter
interface conversionIf;

  logic                       req;
  logic                       ack;
  bikeDisplayPkg::scaled_t    value;
  bikeDisplayPkg::pointMask_t points;
  bikeDisplayPkg::displayMode_t mode;

  // Scaler holds value, points and mode stable while req is high
  modport scaler (
    output req, value, points, mode,
    input  ack
  );

  modport converter (
    input  req, value, points, mode,
    output ack
  );

endinterface

`default_nettype wire

//--- logic/digitsIf.sv
`default_nettype none

// Latest converted digits for the display scan
interface digitsIf;

  bikeDisplayPkg::bcdDigit_t    hundreds;
  bikeDisplayPkg::bcdDigit_t    tens;
  bikeDisplayPkg::bcdDigit_t    ones;
  bikeDisplayPkg::pointMask_t   points;
  bikeDisplayPkg::displayMode_t mode;

  // All fields update together on the converter's ack edge
  modport source (
    output hundreds, tens, ones, points, mode
  );

  modport sink (
    input hundreds, tens, ones, points, mode
  );

endinterface

`default_nettype wire

//--- logic/readingScaler.sv
`default_nettype none

module readingScaler (
  input  wire                          Clock,
  input  wire                          nReset,
  input  bikeDisplayPkg::displayMode_t mode,
  input  bikeDisplayPkg::reading_t     reading,
  conversionIf.scaler                  conv
);

  bikeDisplayPkg::displayMode_t lastMode;
  bikeDisplayPkg::reading_t     lastReading;
  logic                         haveCapture;
  logic                         changed;
  logic                         capture;
  bikeDisplayPkg::scaled_t      scaledNext;
  bikeDisplayPkg::pointMask_t   pointsNext;
  logic [1:0]                   divisions;
  int                           pointIndex;

  // Nothing captured yet counts as a change
  assign changed = !haveCapture || (mode != lastMode) || (reading != lastReading);
  assign capture = changed && !conv.req && !conv.ack;

  ////////////////////
  // Scaling rule
  ////////////////////

  always_comb begin
    if (reading < bikeDisplayPkg::SingleLimit) begin
      scaledNext = bikeDisplayPkg::scaled_t'(reading);
      divisions  = 2'd0;
    end else if (reading < bikeDisplayPkg::TenLimit) begin
      scaledNext = bikeDisplayPkg::scaled_t'(reading / bikeDisplayPkg::ScaleStep);
      divisions  = 2'd1;
    end else begin
      scaledNext = bikeDisplayPkg::scaled_t'(
        reading / (bikeDisplayPkg::ScaleStep * bikeDisplayPkg::ScaleStep));
      divisions  = 2'd2;
    end

    // Point sits on the digit whose index is the remaining fraction count
    pointIndex = bikeDisplayPkg::fractionDigits[mode] - int'(divisions);
    case (pointIndex)
      0:       pointsNext = bikeDisplayPkg::pointMask_t'(1);
      1:       pointsNext = bikeDisplayPkg::pointMask_t'(2);
      default: pointsNext = '0;
    endcase
  end

  ////////////////////
  // Handshake side
  ////////////////////

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      conv.req    <= 1'b0;
      lastMode    <= bikeDisplayPkg::speed;
      lastReading <= '0;
      haveCapture <= 1'b0;
    end else if (capture) begin
      conv.req    <= 1'b1;
      lastMode    <= mode;
      lastReading <= reading;
      haveCapture <= 1'b1;
    end else if (conv.req && conv.ack) begin
      conv.req <= 1'b0;
    end
  end

  // Payload, held while req is up
  always_ff @(posedge Clock) begin
    if (capture) begin
      conv.value  <= scaledNext;
      conv.points <= pointsNext;
      conv.mode   <= mode;
    end
  end

endmodule

`default_nettype wire

//--- logic/bcdConverter.sv
`default_nettype none

module bcdConverter (
  input  wire            Clock,
  input  wire            nReset,
  conversionIf.converter conv,
  digitsIf.source        digits
);

  localparam int StepBits = $clog2(bikeDisplayPkg::ScaledBits + 1);

  typedef enum logic [1:0] {
    idle,
    shift,
    done
  } convState_t;

  convState_t                state;
  logic [StepBits-1:0]       stepCount;
  bikeDisplayPkg::scaled_t   shiftReg;
  bikeDisplayPkg::bcdDigit_t hundredsWork;
  bikeDisplayPkg::bcdDigit_t tensWork;
  bikeDisplayPkg::bcdDigit_t onesWork;
  bikeDisplayPkg::bcdDigit_t hundredsAdj;
  bikeDisplayPkg::bcdDigit_t tensAdj;
  bikeDisplayPkg::bcdDigit_t onesAdj;

  // Digits of five or more are corrected before the shift
  function automatic bikeDisplayPkg::bcdDigit_t addThree(input bikeDisplayPkg::bcdDigit_t d);
    return (d >= 4'd5) ? d + 4'd3 : d;
  endfunction

  always_comb begin
    hundredsAdj = addThree(hundredsWork);
    tensAdj     = addThree(tensWork);
    onesAdj     = addThree(onesWork);
  end

  ////////////////////
  // Control and result
  ////////////////////

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      state           <= idle;
      stepCount       <= '0;
      conv.ack        <= 1'b0;
      digits.hundreds <= '0;
      digits.tens     <= '0;
      digits.ones     <= '0;
      digits.points   <= '0;
      digits.mode     <= bikeDisplayPkg::speed;
    end else begin
      case (state)
        idle: begin
          if (conv.req) begin
            state     <= shift;
            stepCount <= StepBits'(bikeDisplayPkg::ScaledBits);
          end
        end
        shift: begin
          stepCount <= stepCount - 1'b1;
          if (stepCount == StepBits'(1)) begin
            state <= done;
          end
        end
        done: begin
          if (!conv.ack) begin
            // Publish together with ack; req still holds points and mode
            conv.ack        <= 1'b1;
            digits.hundreds <= hundredsWork;
            digits.tens     <= tensWork;
            digits.ones     <= onesWork;
            digits.points   <= conv.points;
            digits.mode     <= conv.mode;
          end else if (!conv.req) begin
            conv.ack <= 1'b0;
            state    <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  ////////////////////
  // Shift-and-add-three
  ////////////////////

  always_ff @(posedge Clock) begin
    if (state == idle && conv.req) begin
      shiftReg     <= conv.value;
      hundredsWork <= '0;
      tensWork     <= '0;
      onesWork     <= '0;
    end else if (state == shift) begin
      shiftReg     <= shiftReg << 1;
      onesWork     <= {onesAdj[2:0], shiftReg[bikeDisplayPkg::ScaledBits-1]};
      tensWork     <= {tensAdj[2:0], onesAdj[3]};
      hundredsWork <= {hundredsAdj[2:0], tensAdj[3]};
    end
  end

endmodule

`default_nettype wire

//--- logic/digitScanner.sv
`default_nettype none

module digitScanner #(
  parameter int RefreshCycles = 50
) (
  input  wire                          Clock,
  input  wire                          nReset,
  digitsIf.sink                        digits,
  output bikeDisplayPkg::digitSelect_t nDigit,
  output bikeDisplayPkg::segments_t    segments,
  output logic                         dp
);

  localparam int CountBits = (RefreshCycles > 0) ? $clog2(RefreshCycles + 1) : 1;
  localparam int TopDigit  = bikeDisplayPkg::NumDigits - 1;

  logic [CountBits-1:0]         frameCount;
  logic                         frameWrap;
  bikeDisplayPkg::digitSelect_t activeDigit;
  bikeDisplayPkg::digitSelect_t nextDigit;
  bikeDisplayPkg::segments_t    segmentsNext;
  logic                         dpNext;

  // Blank for anything that is not a decimal digit
  function automatic bikeDisplayPkg::segments_t glyphOf(input bikeDisplayPkg::bcdDigit_t d);
    if (d <= 4'd9) begin
      return bikeDisplayPkg::digitGlyphs[d];
    end
    return '0;
  endfunction

  assign frameWrap = (frameCount == CountBits'(RefreshCycles));

  ////////////////////
  // Frame timing
  ////////////////////

  // No digit is active until the first frame, which is digit 3
  always_comb begin
    if (activeDigit == bikeDisplayPkg::digitSelect_t'(1) || activeDigit == '0) begin
      nextDigit = bikeDisplayPkg::digitSelect_t'(1) << TopDigit;
    end else begin
      nextDigit = activeDigit >> 1;
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      frameCount  <= '0;
      activeDigit <= '0;
    end else if (frameWrap) begin
      frameCount  <= '0;
      activeDigit <= nextDigit;
    end else begin
      frameCount <= frameCount + 1'b1;
    end
  end

  ////////////////////
  // Segment encoding
  ////////////////////

  always_comb begin
    segmentsNext = '0;
    dpNext       = 1'b0;
    if (activeDigit[TopDigit]) begin
      // Mode letter, never with a point
      segmentsNext = bikeDisplayPkg::modeGlyphs[digits.mode];
    end else if (activeDigit[2]) begin
      segmentsNext = glyphOf(digits.hundreds);
      dpNext       = digits.points[2];
    end else if (activeDigit[1]) begin
      segmentsNext = glyphOf(digits.tens);
      dpNext       = digits.points[1];
    end else if (activeDigit[0]) begin
      segmentsNext = glyphOf(digits.ones);
      dpNext       = digits.points[0];
    end
  end

  // Outputs trail the active digit by one cycle
  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      nDigit   <= '1;
      segments <= '0;
      dp       <= 1'b0;
    end else begin
      nDigit   <= ~activeDigit;
      segments <= segmentsNext;
      dp       <= dpNext;
    end
  end

endmodule

`default_nettype wire

//--- logic/bikeDisplay.sv
`default_nettype none

module bikeDisplay #(
  parameter int RefreshCycles = 50
) (
  input  wire                          Clock,
  input  wire                          nReset,
  input  bikeDisplayPkg::displayMode_t mode,
  input  bikeDisplayPkg::reading_t     reading,
  output bikeDisplayPkg::digitSelect_t nDigit,
  output bikeDisplayPkg::segments_t    segments,
  output logic                         dp
);

  ////////////////////
  // Internal buses
  ////////////////////

  conversionIf convBus ();
  digitsIf     digitBus ();

  // Change detection and scaling
  readingScaler scaler (
    .Clock   (Clock),
    .nReset  (nReset),
    .mode    (mode),
    .reading (reading),
    .conv    (convBus.scaler)
  );

  // Binary to three BCD digits
  bcdConverter converter (
    .Clock  (Clock),
    .nReset (nReset),
    .conv   (convBus.converter),
    .digits (digitBus.source)
  );

  // Multiplexed scan of the four digits
  digitScanner #(
    .RefreshCycles (RefreshCycles)
  ) scanner (
    .Clock    (Clock),
    .nReset   (nReset),
    .digits   (digitBus.sink),
    .nDigit   (nDigit),
    .segments (segments),
    .dp       (dp)
  );

endmodule

`default_nettype wire

//--- tests/bikeDisplay_checker.sv
`default_nettype none

module bikeDisplayChecker (
  input wire                          Clock,
  input wire                          nReset,
  input bikeDisplayPkg::digitSelect_t nDigit,
  input wire                          req,
  input wire                          ack
);

  localparam int MaxAckWait = bikeDisplayPkg::ScaledBits + 2;

  int ackWait;
  int assertFailures = 0;

  // Cycles that req has been waiting for ack
  always @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      ackWait <= 0;
    end else if (req && !ack) begin
      ackWait <= ackWait + 1;
    end else begin
      ackWait <= 0;
    end
  end

  ////////////////////
  // Scan
  ////////////////////

  scanOneHot: assert property (@(posedge Clock) disable iff (!nReset)
    $countones(~nDigit) <= 1)
    else begin
      $error("more than one digit selected, nDigit %b", nDigit);
      assertFailures++;
    end

  ////////////////////
  // Four-phase handshake
  ////////////////////

  reqHeld: assert property (@(posedge Clock) disable iff (!nReset)
    req && !ack |=> req)
    else begin
      $error("req dropped before ack");
      assertFailures++;
    end

  ackHeld: assert property (@(posedge Clock) disable iff (!nReset)
    ack && req |=> ack)
    else begin
      $error("ack dropped while req still high");
      assertFailures++;
    end

  ackInTime: assert property (@(posedge Clock) disable iff (!nReset)
    ackWait <= MaxAckWait)
    else begin
      $error("ack later than %0d cycles after req", MaxAckWait);
      assertFailures++;
    end

endmodule

bind bikeDisplay bikeDisplayChecker protocolCheck (
  .Clock  (Clock),
  .nReset (nReset),
  .nDigit (nDigit),
  .req    (convBus.req),
  .ack    (convBus.ack)
);

`default_nettype wire

//--- tests/displayMonitor.sv
`default_nettype none

module displayMonitor #(
  parameter int RefreshCycles = 7,
  parameter int SettleCycles  = 32
) (
  input wire                          Clock,
  input wire                          nReset,
  input bikeDisplayPkg::displayMode_t mode,
  input bikeDisplayPkg::reading_t     reading,
  input bikeDisplayPkg::digitSelect_t nDigit,
  input bikeDisplayPkg::segments_t    segments,
  input wire                          dp,
  input int                           testId,
  output int                          errorCount,
  output int                          framesChecked
);

  localparam int FrameCycles = RefreshCycles + 1;
  localparam int TopDigit    = bikeDisplayPkg::NumDigits - 1;

  int cycle;
  int lastChange;
  int frameLen;
  int expectedIndex;
  int idx;
  int lastTest = 0;
  int testFrames = 0;
  int testErrors = 0;
  bit scanStarted;
  bit checkFrame;
  bit frameFailed;
  bikeDisplayPkg::displayMode_t lastMode;
  bikeDisplayPkg::reading_t     lastReading;
  bikeDisplayPkg::digitSelect_t lastNDigit;
  bikeDisplayPkg::segments_t    wantSegments;
  logic                         wantPoint;

  initial begin
    errorCount    = 0;
    framesChecked = 0;
  end

  ////////////////////
  // Display model
  ////////////////////

  function automatic int divisionsOf(input bikeDisplayPkg::reading_t r);
    if (r < 16'd1000) return 0;
    if (r < 16'd10000) return 1;
    return 2;
  endfunction

  function automatic bikeDisplayPkg::segments_t glyphFor(
    input bikeDisplayPkg::displayMode_t m,
    input bikeDisplayPkg::reading_t     r,
    input int                           position
  );
    int value;
    int digit;
    value = int'(r);
    for (int k = 0; k < divisionsOf(r); k++) begin
      value = value / 10;
    end
    case (position)
      2:       digit = value / 100;
      1:       digit = (value / 10) % 10;
      default: digit = value % 10;
    endcase
    if (position == TopDigit) return bikeDisplayPkg::modeGlyphs[m];
    return bikeDisplayPkg::digitGlyphs[digit];
  endfunction

  // Point index is what is left of the fraction after scaling
  function automatic logic pointFor(
    input bikeDisplayPkg::displayMode_t m,
    input bikeDisplayPkg::reading_t     r,
    input int                           position
  );
    int lit;
    lit = bikeDisplayPkg::fractionDigits[m] - divisionsOf(r);
    return (lit == 0 || lit == 1) && position == lit;
  endfunction

  // -1 for a blank display, -2 for several digits at once
  function automatic int activeIndex(input bikeDisplayPkg::digitSelect_t n);
    int found;
    found = -1;
    for (int i = 0; i < bikeDisplayPkg::NumDigits; i++) begin
      if (!n[i]) begin
        if (found >= 0) return -2;
        found = i;
      end
    end
    return found;
  endfunction

  task automatic flagMismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    errorCount++;
    testErrors++;
  endtask

  ////////////////////
  // Frame checks
  ////////////////////

  always @(posedge Clock) begin
    if (!nReset) begin
      cycle         = 0;
      lastChange    = 0;
      frameLen      = 0;
      expectedIndex = TopDigit;
      scanStarted   = 1'b0;
      checkFrame    = 1'b0;
      frameFailed   = 1'b0;
      lastMode      = mode;
      lastReading   = reading;
      lastNDigit    = nDigit;
    end else begin
      cycle++;
      if (testId != lastTest) begin
        $display("Test %0d (%s, reading %0d) finished: %0d frames checked, %0d errors",
                 lastTest, lastMode.name(), lastReading, testFrames, testErrors);
        lastTest   = testId;
        testFrames = 0;
        testErrors = 0;
      end
      if (mode != lastMode || reading != lastReading) begin
        lastChange  = cycle;
        lastMode    = mode;
        lastReading = reading;
      end

      idx = activeIndex(nDigit);
      if (nDigit != lastNDigit) begin
        if (scanStarted && frameLen != FrameCycles) begin
          flagMismatch($sformatf("frame lasted %0d cycles, expected %0d",
                                 frameLen, FrameCycles));
        end
        if (idx != expectedIndex) begin
          flagMismatch($sformatf("nDigit %b, expected digit %0d active",
                                 nDigit, expectedIndex));
        end
        expectedIndex = (expectedIndex == 0) ? TopDigit : expectedIndex - 1;
        scanStarted   = 1'b1;
        frameLen      = 1;
        frameFailed   = 1'b0;
        // A change can wait behind a conversion already in flight
        checkFrame    = (idx >= 0) && (cycle - lastChange > SettleCycles);
        if (checkFrame) begin
          wantSegments = glyphFor(mode, reading, idx);
          wantPoint    = pointFor(mode, reading, idx);
          framesChecked++;
          testFrames++;
        end
        lastNDigit = nDigit;
      end else begin
        frameLen++;
      end

      // Blank until the first frame
      if (!scanStarted && (nDigit != '1 || segments != '0 || dp)) begin
        flagMismatch($sformatf("nDigit %b segments %b dp %b before the first frame",
                               nDigit, segments, dp));
      end
      if (checkFrame && !frameFailed && (segments != wantSegments || dp != wantPoint)) begin
        flagMismatch($sformatf("digit %0d shows %b dp %b, expected %b dp %b (%s, %0d)",
                               idx, segments, dp, wantSegments, wantPoint,
                               mode.name(), reading));
        frameFailed = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/bikeDisplayTb.sv
`default_nettype none

module bikeDisplayTb;

  localparam int RefreshCycles = 7;
  localparam int ScanCycles    = (RefreshCycles + 1) * bikeDisplayPkg::NumDigits;
  localparam int HoldScans     = 3;
  localparam int ResetCycles   = 5;
  localparam int BurstLength   = 4;
  localparam int FixedHolds    = 16;
  localparam int RandomHolds   = 24;
  localparam int NumHolds      = FixedHolds + RandomHolds;
  // Every hold with a possible burst in front, plus slack for reset
  localparam int TimeoutCycles = NumHolds * (HoldScans * ScanCycles + BurstLength) + 200;

  localparam bikeDisplayPkg::reading_t boundaries [0:3] = '{
    16'd999, 16'd1000, 16'd9999, 16'd10000
  };

  logic                         Clock;
  logic                         nReset;
  bikeDisplayPkg::displayMode_t mode;
  bikeDisplayPkg::reading_t     reading;
  bikeDisplayPkg::digitSelect_t nDigit;
  bikeDisplayPkg::segments_t    segments;
  logic                         dp;
  int                           testId;
  int                           errorCount;
  int                           framesChecked;
  int                           cycleCount;

  initial Clock = 1'b0;
  always #2 Clock = ~Clock;

  bikeDisplay #(
    .RefreshCycles (RefreshCycles)
  ) DUT (
    .Clock    (Clock),
    .nReset   (nReset),
    .mode     (mode),
    .reading  (reading),
    .nDigit   (nDigit),
    .segments (segments),
    .dp       (dp)
  );

  displayMonitor #(
    .RefreshCycles (RefreshCycles)
  ) monitor (
    .Clock         (Clock),
    .nReset        (nReset),
    .mode          (mode),
    .reading       (reading),
    .nDigit        (nDigit),
    .segments      (segments),
    .dp            (dp),
    .testId        (testId),
    .errorCount    (errorCount),
    .framesChecked (framesChecked)
  );

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic bikeDisplayPkg::displayMode_t randomMode();
    return bikeDisplayPkg::displayMode_t'(2'($urandom % 4));
  endfunction

  // Spread over the three scaling ranges
  function automatic bikeDisplayPkg::reading_t randomReading();
    int range;
    range = int'($urandom % 8);
    if (range == 0) return boundaries[$urandom % 4];
    if (range < 3) return bikeDisplayPkg::reading_t'($urandom % 1000);
    if (range < 5) return bikeDisplayPkg::reading_t'(1000 + $urandom % 9000);
    return bikeDisplayPkg::reading_t'(10000 + $urandom % 55536);
  endfunction

  task automatic applyInput(
    input bikeDisplayPkg::displayMode_t m,
    input bikeDisplayPkg::reading_t     r
  );
    @(negedge Clock);
    mode    = m;
    reading = r;
  endtask

  task automatic holdReading(
    input bikeDisplayPkg::displayMode_t m,
    input bikeDisplayPkg::reading_t     r
  );
    applyInput(m, r);
    repeat (HoldScans * ScanCycles - 1) @(negedge Clock);
    testId++;
  endtask

  // Changes one cycle apart that never settle
  task automatic sendBurst();
    repeat (BurstLength) applyInput(randomMode(), randomReading());
  endtask

  initial begin
    mode    = bikeDisplayPkg::speed;
    reading = '0;
    nReset  = 1'b0;
    testId  = 0;
    void'($urandom(88));
    repeat (ResetCycles) @(negedge Clock);
    nReset = 1'b1;

    // Every mode on every range boundary
    for (int m = 0; m < 4; m++) begin
      for (int b = 0; b < 4; b++) begin
        holdReading(bikeDisplayPkg::displayMode_t'(2'(m)), boundaries[b]);
      end
    end

    for (int i = 0; i < RandomHolds; i++) begin
      if ($urandom % 5 == 0) begin
        sendBurst();
      end
      holdReading(randomMode(), randomReading());
    end

    repeat (2) @(negedge Clock);
    $display("Tests %0d, frames checked %0d, errors %0d, assertion failures %0d",
             testId, framesChecked, errorCount, DUT.protocolCheck.assertFailures);
    if (errorCount == 0 && framesChecked > 0 && DUT.protocolCheck.assertFailures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  ////////////////////
  // Timeout
  ////////////////////

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge Clock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/bikeDisplayPkg.sv
logic/conversionIf.sv
logic/digitsIf.sv
logic/readingScaler.sv
logic/bcdConverter.sv
logic/digitScanner.sv
logic/bikeDisplay.sv
tests/bikeDisplay_checker.sv
tests/displayMonitor.sv
tests/bikeDisplayTb.sv

//--- Makefile
TOP := bikeDisplayTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --assert -f sim.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "test passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
